// ==== adapterPkg.sv ====
package adapterPkg;

    localparam int fifoDepth = 32; // entries per dual-clock FIFO
    localparam int fifoAddrBits = 5; // pointer width without the wrap bit

    localparam int inputReadyLimit = 27; // oready allowed at or below this used count
    localparam int outputReadyLimit = 20; // leaves room for pipeline, ready delay and count lag
    localparam int readyDelay = 2; // clock2x registers on the fast ready
    localparam int accStages = 3; // accumulator latency in clock2x cycles

    localparam int rstSyncStages = 4; // synchronizer into clock2x
    localparam int rstPipeStages = 5; // extra delay after the synchronizer

    localparam int countBits = 16; // pcoeff count width
    localparam int sumBits = 48; // summed popcount width

    // one input beat, botLower doubles as the new top
    typedef struct packed {
        logic        startNewTop;
        logic [63:0] botLower;
        logic [63:0] botUpper;
    } inBeatT;

    typedef logic [countBits+sumBits-1:0] resultT; // count above sum

endpackage

// ==== clock2xAdapter.sv ====
`timescale 1ns/1ps

module clock2xAdapter import adapterPkg::*; (
    input  logic        clock,
    input  logic        clock2x,
    input  logic        rstN,
    input  logic        ivalid,
    output logic        oready,
    input  logic [63:0] botLower,
    input  logic [63:0] botUpper,
    input  logic        startNewTop,
    output logic        ovalid,
    input  logic        iready,
    output logic [63:0] summedDataPcoeffCountOut
);

    logic                    rst;
    logic                    rst2x;
    logic                    isInitialized;
    inBeatT                  writeBeat;
    logic                    receivingData;
    logic [fifoAddrBits-1:0] inputUsed;
    logic                    fastValid;
    inBeatT                  fastBeat;
    logic [readyDelay-1:0]   readyPipe;
    logic                    fastReady;
    logic                    accValid;
    resultT                  accResult;
    logic [fifoAddrBits-1:0] outputUsed;

    resetSync i_resetSync (
        .clock         (clock),
        .clock2x       (clock2x),
        .rstN          (rstN),
        .rst           (rst),
        .isInitialized (isInitialized),
        .rst2x         (rst2x)
    );

    assign oready = (inputUsed <= inputReadyLimit) && isInitialized;
    assign receivingData = oready && ivalid;

    assign writeBeat.startNewTop = startNewTop;
    assign writeBeat.botLower = botLower; // also the new top on a startNewTop beat
    assign writeBeat.botUpper = botUpper;

    dualClockFifo #(.payloadT(inBeatT)) i_inputFifo (
        .wrClock     (clock),
        .wrRst       (rst),
        .writeEnable (receivingData),
        .dataIn      (writeBeat),
        .wrUsed      (inputUsed),
        .rdClock     (clock2x),
        .rdRst       (rst2x),
        .readEnable  (fastReady),
        .dataValid   (fastValid),
        .dataOut     (fastBeat)
    );

    // output FIFO room, registered then delayed
    always_ff @(posedge clock2x or posedge rst2x) begin
        if (rst2x) begin
            readyPipe <= '0;
        end else begin
            readyPipe[0] <= outputUsed <= outputReadyLimit;
            for (int i = 1; i < readyDelay; i++) begin
                readyPipe[i] <= readyPipe[i-1];
            end
        end
    end

    assign fastReady = readyPipe[readyDelay-1];

    topSubsetAccumulator i_accumulator (
        .clock2x   (clock2x),
        .rst2x     (rst2x),
        .inValid   (fastValid),
        .inBeat    (fastBeat),
        .inReady   (fastReady),
        .outValid  (accValid),
        .outResult (accResult)
    );

    dualClockFifo #(.payloadT(resultT)) i_outputFifo (
        .wrClock     (clock2x),
        .wrRst       (rst2x),
        .writeEnable (accValid), // pipeline never stalls
        .dataIn      (accResult),
        .wrUsed      (outputUsed),
        .rdClock     (clock),
        .rdRst       (rst),
        .readEnable  (iready || !ovalid), // pull the next word in while idle
        .dataValid   (ovalid),
        .dataOut     (summedDataPcoeffCountOut)
    );

endmodule

// ==== dualClockFifo.sv ====
`timescale 1ns/1ps

module dualClockFifo import adapterPkg::*; #(
    parameter type payloadT = logic [63:0]
) (
    input  logic                    wrClock,
    input  logic                    wrRst,
    input  logic                    writeEnable,
    input  payloadT                 dataIn,
    output logic [fifoAddrBits-1:0] wrUsed,
    input  logic                    rdClock,
    input  logic                    rdRst,
    input  logic                    readEnable,
    output logic                    dataValid,
    output payloadT                 dataOut
);

    payloadT mem [fifoDepth];

    logic [fifoAddrBits:0] wrPtrBin;
    logic [fifoAddrBits:0] wrPtrGray;
    logic [fifoAddrBits:0] wrPtrNext;
    logic [fifoAddrBits:0] rdGrayMeta;
    logic [fifoAddrBits:0] rdGraySync;
    logic [fifoAddrBits:0] rdPtrBinSync;
    logic [fifoAddrBits:0] usedCount;
    logic                  full;
    logic                  writeAccept;

    logic [fifoAddrBits:0] rdPtrBin;
    logic [fifoAddrBits:0] rdPtrGray;
    logic [fifoAddrBits:0] rdPtrNext;
    logic [fifoAddrBits:0] wrGrayMeta;
    logic [fifoAddrBits:0] wrGraySync;
    logic                  empty;
    logic                  readAccept;

    function automatic logic [fifoAddrBits:0] grayToBin(input logic [fifoAddrBits:0] gray);
        logic [fifoAddrBits:0] bin;
        bin[fifoAddrBits] = gray[fifoAddrBits];
        for (int i = fifoAddrBits - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // write side
    assign rdPtrBinSync = grayToBin(rdGraySync);
    assign usedCount = wrPtrBin - rdPtrBinSync; // lags reads, so never underestimates
    assign full = usedCount[fifoAddrBits];
    assign wrUsed = usedCount[fifoAddrBits-1:0];
    assign writeAccept = writeEnable && !full;
    assign wrPtrNext = wrPtrBin + 1'b1;

    always_ff @(posedge wrClock or posedge wrRst) begin
        if (wrRst) begin
            wrPtrBin <= '0;
            wrPtrGray <= '0;
            rdGrayMeta <= '0;
            rdGraySync <= '0;
        end else begin
            rdGrayMeta <= rdPtrGray; // crossing from rdClock
            rdGraySync <= rdGrayMeta;
            if (writeAccept) begin
                wrPtrBin <= wrPtrNext;
                wrPtrGray <= wrPtrNext ^ (wrPtrNext >> 1);
            end
        end
    end

    always_ff @(posedge wrClock) begin
        if (writeAccept) begin
            mem[wrPtrBin[fifoAddrBits-1:0]] <= dataIn;
        end
    end

    // read side, head word shown before it is taken
    assign empty = (rdPtrGray == wrGraySync);
    assign dataValid = !empty;
    assign dataOut = mem[rdPtrBin[fifoAddrBits-1:0]];
    assign readAccept = readEnable && !empty;
    assign rdPtrNext = rdPtrBin + 1'b1;

    always_ff @(posedge rdClock or posedge rdRst) begin
        if (rdRst) begin
            rdPtrBin <= '0;
            rdPtrGray <= '0;
            wrGrayMeta <= '0;
            wrGraySync <= '0;
        end else begin
            wrGrayMeta <= wrPtrGray; // crossing from wrClock
            wrGraySync <= wrGrayMeta;
            if (readAccept) begin
                rdPtrBin <= rdPtrNext;
                rdPtrGray <= rdPtrNext ^ (rdPtrNext >> 1);
            end
        end
    end

    noWriteWhenFull: assert property (@(posedge wrClock) disable iff (wrRst)
        full |-> !writeEnable)
        else $error("write attempted while FIFO is full");

    headHeld: assert property (@(posedge rdClock) disable iff (rdRst)
        dataValid && !readEnable |=> dataValid && $stable(dataOut))
        else $error("head word changed while waiting for readEnable");

endmodule

// ==== files.f ====
adapterPkg.sv
resetSync.sv
dualClockFifo.sv
topSubsetAccumulator.sv
clock2xAdapter.sv
tbClock2xAdapter.sv

// ==== resetSync.sv ====
`timescale 1ns/1ps

module resetSync import adapterPkg::*; (
    input  logic clock,
    input  logic clock2x,
    input  logic rstN,
    output logic rst,
    output logic isInitialized,
    output logic rst2x
);

    logic [1:0]               rstChain;
    logic [rstSyncStages-1:0] initChain;
    logic [rstSyncStages-1:0] rst2xSync;
    logic [rstPipeStages-1:0] rst2xPipe;

    // async assert, release on clock
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            rstChain <= 2'b11;
        end else begin
            rstChain <= {rstChain[0], 1'b0};
        end
    end

    assign rst = rstChain[1];

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            initChain <= '0;
        end else begin
            initChain <= {initChain[rstSyncStages-2:0], 1'b1}; // walk ones in after release
        end
    end

    assign isInitialized = initChain[rstSyncStages-1];

    // fast reset is set at once by rst and released late, so the slow side
    // may already be writing into the input FIFO when clock2x logic wakes up
    always_ff @(posedge clock2x or posedge rst) begin
        if (rst) begin
            rst2xSync <= '1;
            rst2xPipe <= '1;
        end else begin
            rst2xSync <= {rst2xSync[rstSyncStages-2:0], 1'b0};
            rst2xPipe <= {rst2xPipe[rstPipeStages-2:0], rst2xSync[rstSyncStages-1]};
        end
    end

    assign rst2x = rst2xPipe[rstPipeStages-1];

    initAfterReset: assert property (@(posedge clock) rst |-> !isInitialized)
        else $error("isInitialized high while rst is asserted");

endmodule

// ==== tbClock2xAdapter.sv ====
`timescale 1ns/1ps

module tbClock2xAdapter import adapterPkg::*; ();

    localparam int rstCycles = 4;
    localparam int readyTimeout = 200; // clock cycles
    localparam int beatTimeout = 500;
    localparam int drainTimeout = 5000;
    localparam int randomBeats = 300;

    logic        clock = 1'b0;
    logic        clock2x = 1'b0;
    logic        rstN;
    logic        ivalid;
    logic        oready;
    logic [63:0] botLower;
    logic [63:0] botUpper;
    logic        startNewTop;
    logic        ovalid;
    logic        iready;
    logic [63:0] summedDataPcoeffCountOut;

    resultT               expectedQueue [$];
    resultT               expectedHead;
    logic                 expectedPending;
    logic [63:0]          modelTop;
    logic [countBits-1:0] modelCount;
    logic [sumBits-1:0]   modelSum;
    logic [63:0]          stimTop; // top as seen by the pattern generator
    logic                 randomReady;
    int                   readyHold;
    int                   errorCount;
    int                   resultsChecked;
    int                   beatsSent;
    logic                 timedOut;

    always #2 clock = ~clock;
    always #1 clock2x = ~clock2x;

    clock2xAdapter i_clock2xAdapter (
        .clock                    (clock),
        .clock2x                  (clock2x),
        .rstN                     (rstN),
        .ivalid                   (ivalid),
        .oready                   (oready),
        .botLower                 (botLower),
        .botUpper                 (botUpper),
        .startNewTop              (startNewTop),
        .ovalid                   (ovalid),
        .iready                   (iready),
        .summedDataPcoeffCountOut (summedDataPcoeffCountOut)
    );

    function automatic logic isSubset(input logic [63:0] pattern, input logic [63:0] top);
        return (pattern | top) == top;
    endfunction

    function automatic logic [63:0] makePattern(input logic [63:0] top);
        logic [63:0] pattern;
        pattern = {$urandom, $urandom};
        if ($urandom % 2 == 0) begin
            pattern = pattern & top; // force a subset about half the time
        end
        return pattern;
    endfunction

    // reference model updated on every accepted beat
    always @(posedge clock) begin
        if (rstN) begin
            if (ovalid && iready) begin
                resultsChecked++;
                if (expectedQueue.size() != 0) begin
                    void'(expectedQueue.pop_front());
                end
            end
            if (ivalid && oready) begin
                beatsSent++;
                if (startNewTop) begin
                    modelTop = botLower;
                    modelCount = '0;
                    modelSum = '0;
                end else begin
                    if (isSubset(botLower, modelTop)) begin
                        modelCount++;
                        modelSum += sumBits'($countones(botLower));
                    end
                    if (isSubset(botUpper, modelTop)) begin
                        modelCount++;
                        modelSum += sumBits'($countones(botUpper));
                    end
                    expectedQueue.push_back({modelCount, modelSum});
                end
            end
            expectedPending <= expectedQueue.size() != 0;
            expectedHead <= (expectedQueue.size() != 0) ? expectedQueue[0] : '0;
        end
    end

    // sink readiness with long low stretches that fill both FIFOs
    always @(posedge clock) begin
        if (!rstN || !randomReady) begin
            iready <= 1'b1;
            readyHold <= 0;
        end else if (readyHold != 0) begin
            readyHold <= readyHold - 1;
        end else begin
            iready <= !iready;
            readyHold <= iready ? int'($urandom % 60) : int'($urandom % 6);
        end
    end

    resultMatches: assert property (@(posedge clock) disable iff (!rstN)
        ovalid && iready && expectedPending |-> summedDataPcoeffCountOut == expectedHead)
        else begin
            errorCount++;
            $display("mismatch summedDataPcoeffCountOut: got %h, expected %h",
                $sampled(summedDataPcoeffCountOut), $sampled(expectedHead));
        end

    noExtraResult: assert property (@(posedge clock) disable iff (!rstN)
        ovalid && iready |-> expectedPending)
        else begin
            errorCount++;
            $display("a result arrived while none was expected");
        end

    holdWhileStalled: assert property (@(posedge clock) disable iff (!rstN)
        ovalid && !iready |=> ovalid && $stable(summedDataPcoeffCountOut))
        else begin
            errorCount++;
            $display("output changed while ovalid was high and iready low");
        end

    quietInReset: assert property (@(posedge clock) !rstN && $past(!rstN) |-> !ovalid && !oready)
        else begin
            errorCount++;
            $display("ovalid or oready high while rstN is low");
        end

    quietAfterReset: assert property (@(posedge clock)
        $rose(rstN) |-> (!ovalid && !oready) ##1 (!ovalid && !oready))
        else begin
            errorCount++;
            $display("ovalid or oready high right after reset release");
        end

    task automatic noteTimeout(input string what);
        timedOut = 1'b1;
        errorCount++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic waitForReady();
        int waited;
        waited = 0;
        while (!oready && waited < readyTimeout) begin
            @(posedge clock);
            waited++;
        end
        if (!oready) begin
            noteTimeout("oready after reset");
        end
    endtask

    task automatic sendBeat(input logic newTop, input logic [63:0] lower,
                            input logic [63:0] upper);
        int waited;
        waited = 0;
        @(posedge clock);
        ivalid <= 1'b1;
        startNewTop <= newTop;
        botLower <= lower;
        botUpper <= upper;
        if (newTop) begin
            stimTop = lower;
        end
        do begin
            @(posedge clock);
            waited++;
        end while (!oready && waited < beatTimeout);
        ivalid <= 1'b0;
        if (!oready) begin
            noteTimeout("an input handshake");
        end
    endtask

    task automatic runDirected();
        logic [63:0] top;
        top = 64'hF0F0_00FF_8421_3C3C;
        sendBeat(1'b1, top, 64'h0);
        sendBeat(1'b0, 64'h8080_0001_0001_0404, 64'h0); // both patterns count
        sendBeat(1'b0, top, 64'h0000_00F0_0000_0000);
        sendBeat(1'b0, 64'h0F00_0000_0000_0000, 64'h2); // both miss so totals repeat
        sendBeat(1'b1, 64'hFF, 64'hFFFF_FFFF_FFFF_FFFF); // restart from zero
        sendBeat(1'b0, 64'h0F, 64'hF0);
        sendBeat(1'b0, 64'h100, 64'h1); // upper counts only
    endtask

    task automatic runRandom(input int beats);
        for (int i = 0; i < beats && !timedOut; i++) begin
            if ($urandom % 12 == 0) begin
                sendBeat(1'b1, {$urandom, $urandom} | {$urandom, $urandom}, {$urandom, $urandom});
            end else begin
                sendBeat(1'b0, makePattern(stimTop), makePattern(stimTop));
            end
            repeat ($urandom % 3) @(posedge clock);
        end
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        randomReady <= 1'b0;
        while (expectedQueue.size() != 0 && waited < drainTimeout) begin
            @(posedge clock);
            waited++;
        end
        if (expectedQueue.size() != 0) begin
            noteTimeout("the remaining expected results");
        end
        repeat (20) @(posedge clock); // room for a stray extra result
    endtask

    task automatic reportAndFinish();
        $display("errors: %0d, results checked: %0d, beats accepted: %0d",
            errorCount, resultsChecked, beatsSent);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        rstN = 1'b0;
        ivalid = 1'b0;
        startNewTop = 1'b0;
        botLower = '0;
        botUpper = '0;
        iready = 1'b1;
        randomReady = 1'b0;
        stimTop = '0;
        modelTop = '0; // accumulator top is zero after reset
        modelCount = '0;
        modelSum = '0;
        expectedPending = 1'b0;
        expectedHead = '0;
        errorCount = 0;
        resultsChecked = 0;
        beatsSent = 0;
        timedOut = 1'b0;
        void'($urandom(76));
        repeat (rstCycles) @(posedge clock);
        rstN <= 1'b1;
        waitForReady();
        if (!timedOut) begin
            runDirected();
        end
        randomReady <= 1'b1;
        if (!timedOut) begin
            runRandom(randomBeats);
        end
        if (!timedOut) begin
            drainResults();
        end
        reportAndFinish();
    end

endmodule

// ==== topSubsetAccumulator.sv ====
`timescale 1ns/1ps

module topSubsetAccumulator import adapterPkg::*; (
    input  logic   clock2x,
    input  logic   rst2x,
    input  logic   inValid,
    input  inBeatT inBeat,
    input  logic   inReady,
    output logic   outValid,
    output resultT outResult
);

    logic                 s1Valid;
    inBeatT               s1Beat;
    logic [63:0]          top;
    logic                 loadTop;
    logic                 lowerHit;
    logic                 upperHit;
    logic [6:0]           lowerOnes;
    logic [6:0]           upperOnes;
    logic                 s2Valid;
    logic [1:0]           s2AddCount;
    logic [7:0]           s2AddSum;
    logic [countBits-1:0] countTotal;
    logic [countBits-1:0] countNext;
    logic [sumBits-1:0]   sumTotal;
    logic [sumBits-1:0]   sumNext;

    function automatic logic [6:0] popCount(input logic [63:0] pattern);
        logic [6:0] ones;
        ones = '0;
        for (int i = 0; i < 64; i++) begin
            ones = ones + 7'(pattern[i]);
        end
        return ones;
    endfunction

    // stage 1, capture accepted beat
    always_ff @(posedge clock2x or posedge rst2x) begin
        if (rst2x) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= inValid && inReady;
        end
    end

    always_ff @(posedge clock2x) begin
        if (inValid && inReady) begin
            s1Beat <= inBeat;
        end
    end

    // stage 2, subset test against current top
    assign loadTop = s1Valid && s1Beat.startNewTop;
    assign lowerHit = (s1Beat.botLower & ~top) == '0; // no bit outside the top
    assign upperHit = (s1Beat.botUpper & ~top) == '0;
    assign lowerOnes = lowerHit ? popCount(s1Beat.botLower) : '0;
    assign upperOnes = upperHit ? popCount(s1Beat.botUpper) : '0;

    always_ff @(posedge clock2x or posedge rst2x) begin
        if (rst2x) begin
            s2Valid <= 1'b0;
            top <= '0;
        end else begin
            s2Valid <= s1Valid && !s1Beat.startNewTop; // top beats give no result
            if (loadTop) begin
                top <= s1Beat.botLower;
            end
        end
    end

    always_ff @(posedge clock2x) begin
        s2AddCount <= 2'(lowerHit) + 2'(upperHit);
        s2AddSum <= 8'(lowerOnes) + 8'(upperOnes);
    end

    // stage 3, running totals
    // a beat still in stage 3 when the next top loads keeps its old totals
    assign countNext = countTotal + countBits'(s2AddCount);
    assign sumNext = sumTotal + sumBits'(s2AddSum);

    always_ff @(posedge clock2x or posedge rst2x) begin
        if (rst2x) begin
            outValid <= 1'b0;
            countTotal <= '0;
            sumTotal <= '0;
        end else begin
            outValid <= s2Valid;
            if (loadTop) begin
                countTotal <= '0; // cleared alongside the top load
                sumTotal <= '0;
            end else if (s2Valid) begin
                countTotal <= countNext;
                sumTotal <= sumNext;
            end
        end
    end

    always_ff @(posedge clock2x) begin
        if (s2Valid) begin
            outResult <= {countNext, sumNext};
        end
    end

    topBeatSilent: assert property (@(posedge clock2x) disable iff (rst2x)
        inValid && inReady && inBeat.startNewTop |-> ##accStages !outValid)
        else $error("outValid raised for a startNewTop beat");

endmodule
